/* rtl/flash_pkg.sv */
// flash exerciser package, SPI NOR opcodes, status bit, sequencer steps and test pattern
package flash_pkg;

	// ------------------------------------------------------------------------
	// SPI NOR opcodes
	// ------------------------------------------------------------------------
	localparam logic [7:0] op_wren         = 8'h06;
	localparam logic [7:0] op_sector_erase = 8'h20;
	localparam logic [7:0] op_read_status  = 8'h05;
	localparam logic [7:0] op_page_program = 8'h02;
	localparam logic [7:0] op_read         = 8'h03;

	// write-in-progress flag in the status byte
	localparam int wip_bit = 0;

	// byte i of the test page holds i + pattern_base
	localparam logic [7:0] pattern_base = 8'h3c;

	// 24-bit flash byte address
	typedef logic [23:0] addr_t;

	// ------------------------------------------------------------------------
	// sequencer steps, one flash command each
	// ------------------------------------------------------------------------
	typedef enum logic [3:0] {
		step_idle,
		step_wren_erase,   // write enable ahead of erase
		step_erase,
		step_poll_erase,
		step_wren_prog,    // write enable ahead of page program
		step_program,
		step_poll_prog,
		step_read_back,
		step_finish
	} seq_step_t;

endpackage

/* rtl/flash_ifs.sv */
// command handshake and credit-based byte stream interfaces for the flash exerciser
`timescale 1ns/1ps

// ----------------------------------------------------------------------------
// one command from the sequencer to the SPI engine
// ----------------------------------------------------------------------------
interface flash_cmd_if;

	logic             req;        // held until ack
	logic [7:0]       opcode;
	flash_pkg::addr_t addr;
	logic             has_addr;   // low for opcode-only frames
	logic [8:0]       len;        // data phase bytes, 0 to 256
	logic             dir;        // 0 write, 1 read
	logic             ack;        // one cycle, command taken
	logic             done;       // one cycle, frame over and cs high long enough

	modport seq (
		output req,
		output opcode,
		output addr,
		output has_addr,
		output len,
		output dir,
		input  ack,
		input  done
	);

	modport engine (
		input  req,
		input  opcode,
		input  addr,
		input  has_addr,
		input  len,
		input  dir,
		output ack,
		output done
	);

endinterface

// ----------------------------------------------------------------------------
// byte stream, valid only while the sender holds a credit
// ----------------------------------------------------------------------------
interface flash_byte_if;

	logic       valid;
	logic [7:0] data;
	logic       credit;     // one pulse hands one credit back

	modport sender (
		output valid,
		output data,
		input  credit
	);

	modport receiver (
		input  valid,
		input  data,
		output credit
	);

endinterface

/* rtl/spi_flash_engine.sv */
// SPI mode 0 bit engine, frames opcode, address and data bytes under chip select
`timescale 1ns/1ps

module spi_flash_engine #(
	parameter int CS_HIGH_CYCLES = 4
) (
	input  logic         clk_100m,
	input  logic         sys_rst_n,

	flash_cmd_if.engine   cmd,
	flash_byte_if.receiver wr_bytes,
	flash_byte_if.sender  rd_bytes,

	output logic         spi_cs_n,
	output logic         spi_clk,
	output logic         spi_mosi,
	input  logic         spi_miso
);

	localparam int GW = $clog2(CS_HIGH_CYCLES + 1);

	typedef enum logic [2:0] {
		E_IDLE,
		E_ACK,    // ack out, cs falls next
		E_CS,     // cs low, first bit set up
		E_LOW,    // spi_clk low
		E_HIGH,   // spi_clk high
		E_WAIT,   // byte boundary stall, clock parked low
		E_END,    // last bit done, cs rises next
		E_GAP     // minimum cs high time
	} eng_state_t;

	eng_state_t state;

	logic [2:0]    bit_cnt;
	logic [8:0]    bytes_left;   // bytes still to frame after the current one
	logic [1:0]    addr_left;
	logic          dir_rd;
	logic          cur_rd;       // current byte is read data
	logic [GW-1:0] gap_cnt;
	logic          ack_r;
	logic          done_r;

	logic [7:0]    tx_sh;
	logic [7:0]    rx_sh;
	logic [23:0]   addr_sh;

	// write side buffer
	logic [7:0]    wbuf [0:1];
	logic          wb_wp;
	logic          wb_rp;
	logic [1:0]    wb_cnt;
	logic          wr_cred_r;

	// read side credits, full count is 2
	logic [1:0]    rd_credit;
	logic          rd_valid_r;

	logic          accept;
	logic          boundary;
	logic          next_is_addr;
	logic          next_ready;
	logic [7:0]    next_byte;
	logic          load_next;
	logic          pop;
	logic          rd_push;

	assign accept       = (state == E_IDLE) && cmd.req;
	assign next_is_addr = (addr_left != 2'd0);
	assign next_ready   = next_is_addr || (dir_rd ? (rd_credit != 2'd0) : (wb_cnt != 2'd0));
	assign next_byte    = next_is_addr ? addr_sh[23:16] : (dir_rd ? 8'h00 : wbuf[wb_rp]);
	assign boundary     = ((state == E_HIGH) && (bit_cnt == 3'd7) && (bytes_left != 9'd0))
	                      || (state == E_WAIT);
	assign load_next    = boundary && next_ready;
	assign pop          = load_next && !next_is_addr && !dir_rd;
	assign rd_push      = (state == E_LOW) && (bit_cnt == 3'd7) && cur_rd;   // last bit sampled

	assign cmd.ack         = ack_r;
	assign cmd.done        = done_r;
	assign wr_bytes.credit = wr_cred_r;
	assign rd_bytes.valid  = rd_valid_r;
	assign rd_bytes.data   = rx_sh;   // stable until the next rising edge

	// ------------------------------------------------------------------------
	// frame FSM and pins
	// ------------------------------------------------------------------------
	always_ff @(posedge clk_100m or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state      <= E_IDLE;
			bit_cnt    <= 3'd0;
			bytes_left <= 9'd0;
			addr_left  <= 2'd0;
			dir_rd     <= 1'b0;
			cur_rd     <= 1'b0;
			gap_cnt    <= '0;
			ack_r      <= 1'b0;
			done_r     <= 1'b0;
			spi_cs_n   <= 1'b1;
			spi_clk    <= 1'b0;
			spi_mosi   <= 1'b0;
		end else begin
			done_r <= 1'b0;
			case (state)
				E_IDLE: begin
					if (cmd.req) begin
						ack_r      <= 1'b1;
						dir_rd     <= cmd.dir;
						cur_rd     <= 1'b0;
						bit_cnt    <= 3'd0;
						addr_left  <= cmd.has_addr ? 2'd3 : 2'd0;
						bytes_left <= (cmd.has_addr ? 9'd3 : 9'd0) + cmd.len;
						state      <= E_ACK;
					end
				end
				E_ACK: begin
					ack_r    <= 1'b0;
					spi_cs_n <= 1'b0;
					state    <= E_CS;
				end
				E_CS: begin
					spi_mosi <= tx_sh[7];   // opcode msb
					state    <= E_LOW;
				end
				E_LOW: begin
					spi_clk <= 1'b1;
					state   <= E_HIGH;
				end
				E_HIGH: begin
					spi_clk <= 1'b0;
					if (bit_cnt != 3'd7) begin
						spi_mosi <= tx_sh[6];
						bit_cnt  <= bit_cnt + 3'd1;
						state    <= E_LOW;
					end else if (bytes_left == 9'd0) begin
						spi_mosi <= 1'b0;
						state    <= E_END;
					end else begin
						state <= E_WAIT;   // left at once when the next byte is ready
					end
				end
				E_WAIT: ;
				E_END: begin
					spi_cs_n <= 1'b1;
					gap_cnt  <= '0;
					state    <= E_GAP;
				end
				E_GAP: begin
					if (gap_cnt == GW'(CS_HIGH_CYCLES - 1)) begin
						done_r <= 1'b1;
						state  <= E_IDLE;
					end else begin
						gap_cnt <= gap_cnt + 1'b1;
					end
				end
				default: state <= E_IDLE;
			endcase

			// next byte into the shifter, same cycle spi_clk goes low
			if (load_next) begin
				spi_mosi   <= next_byte[7];
				bit_cnt    <= 3'd0;
				bytes_left <= bytes_left - 9'd1;
				cur_rd     <= !next_is_addr && dir_rd;
				if (next_is_addr)
					addr_left <= addr_left - 2'd1;
				state      <= E_LOW;
			end
		end
	end

	// shifters and buffer storage
	always_ff @(posedge clk_100m) begin
		if (accept) begin
			tx_sh   <= cmd.opcode;
			addr_sh <= cmd.addr;
		end else if (load_next) begin
			tx_sh <= next_byte;
			if (next_is_addr)
				addr_sh <= {addr_sh[15:0], 8'h00};
		end else if ((state == E_HIGH) && (bit_cnt != 3'd7)) begin
			tx_sh <= {tx_sh[6:0], 1'b0};
		end

		if (state == E_LOW)
			rx_sh <= {rx_sh[6:0], spi_miso};   // sampled as spi_clk rises

		if (wr_bytes.valid)
			wbuf[wb_wp] <= wr_bytes.data;
	end

	// ------------------------------------------------------------------------
	// credit bookkeeping, both directions
	// ------------------------------------------------------------------------
	always_ff @(posedge clk_100m or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			wb_wp      <= 1'b0;
			wb_rp      <= 1'b0;
			wb_cnt     <= 2'd0;
			wr_cred_r  <= 1'b0;
			rd_credit  <= 2'd2;
			rd_valid_r <= 1'b0;
		end else begin
			wr_cred_r  <= pop;   // slot freed
			rd_valid_r <= rd_push;
			if (wr_bytes.valid)
				wb_wp <= ~wb_wp;
			if (pop)
				wb_rp <= ~wb_rp;
			case ({wr_bytes.valid, pop})
				2'b10:   wb_cnt <= wb_cnt + 2'd1;
				2'b01:   wb_cnt <= wb_cnt - 2'd1;
				default: ;
			endcase
			case ({rd_bytes.credit, rd_push})
				2'b10:   rd_credit <= rd_credit + 2'd1;
				2'b01:   rd_credit <= rd_credit - 2'd1;
				default: ;
			endcase
		end
	end

endmodule

/* rtl/flash_test_seq.sv */
// flash test sequencer, walks the erase-program-read steps and checks the read-back page
`timescale 1ns/1ps

module flash_test_seq #(
	parameter int               PAGE_BYTES = 16,
	parameter flash_pkg::addr_t TEST_ADDR  = 24'h001000
) (
	input  logic         clk_100m,
	input  logic         sys_rst_n,
	input  logic         start,
	output logic         busy,
	output logic         done,
	output logic         error_flag,

	flash_cmd_if.seq      cmd,
	flash_byte_if.sender  wr_bytes,
	flash_byte_if.receiver rd_bytes
);

	localparam int IW = $clog2(PAGE_BYTES + 1);

	flash_pkg::seq_step_t step;
	flash_pkg::seq_step_t step_nxt;

	logic          req_r;
	logic          status_wip;   // last polled write-in-progress bit
	logic [IW-1:0] wr_idx;
	logic [IW-1:0] rd_idx;
	logic [1:0]    wr_credit;
	logic          wr_send;
	logic          wr_valid_r;
	logic [7:0]    wr_data_r;
	logic          rd_cred_r;
	logic          is_poll;
	logic          mismatch;

	function automatic flash_pkg::seq_step_t next_step(input flash_pkg::seq_step_t cur,
	                                                   input logic wip);
		case (cur)
			flash_pkg::step_wren_erase: next_step = flash_pkg::step_erase;
			flash_pkg::step_erase:      next_step = flash_pkg::step_poll_erase;
			flash_pkg::step_poll_erase:
				next_step = wip ? flash_pkg::step_poll_erase : flash_pkg::step_wren_prog;
			flash_pkg::step_wren_prog:  next_step = flash_pkg::step_program;
			flash_pkg::step_program:    next_step = flash_pkg::step_poll_prog;
			flash_pkg::step_poll_prog:
				next_step = wip ? flash_pkg::step_poll_prog : flash_pkg::step_read_back;
			flash_pkg::step_read_back:  next_step = flash_pkg::step_finish;
			default:                    next_step = flash_pkg::step_idle;
		endcase
	endfunction

	assign step_nxt = next_step(step, status_wip);
	assign is_poll  = (step == flash_pkg::step_poll_erase) || (step == flash_pkg::step_poll_prog);
	assign mismatch = (step == flash_pkg::step_read_back) && rd_bytes.valid
	                  && (rd_bytes.data != 8'(rd_idx) + flash_pkg::pattern_base);

	// ------------------------------------------------------------------------
	// command fields, constant for the whole step
	// ------------------------------------------------------------------------
	always_comb begin
		cmd.req      = req_r;
		cmd.addr     = TEST_ADDR;
		cmd.opcode   = flash_pkg::op_wren;
		cmd.has_addr = 1'b0;
		cmd.len      = 9'd0;
		cmd.dir      = 1'b0;
		case (step)
			flash_pkg::step_erase: begin
				cmd.opcode   = flash_pkg::op_sector_erase;
				cmd.has_addr = 1'b1;
			end
			flash_pkg::step_poll_erase, flash_pkg::step_poll_prog: begin
				cmd.opcode = flash_pkg::op_read_status;
				cmd.len    = 9'd1;
				cmd.dir    = 1'b1;
			end
			flash_pkg::step_program: begin
				cmd.opcode   = flash_pkg::op_page_program;
				cmd.has_addr = 1'b1;
				cmd.len      = 9'(PAGE_BYTES);
			end
			flash_pkg::step_read_back: begin
				cmd.opcode   = flash_pkg::op_read;
				cmd.has_addr = 1'b1;
				cmd.len      = 9'(PAGE_BYTES);
				cmd.dir      = 1'b1;
			end
			default: ;   // both write enables keep the defaults
		endcase
	end

	// step walk, one command outstanding
	always_ff @(posedge clk_100m or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			step       <= flash_pkg::step_idle;
			req_r      <= 1'b0;
			busy       <= 1'b0;
			done       <= 1'b0;
			error_flag <= 1'b0;
		end else begin
			done <= 1'b0;
			if (cmd.ack)
				req_r <= 1'b0;
			if (mismatch)
				error_flag <= 1'b1;   // sticky until next start
			case (step)
				flash_pkg::step_idle: begin
					if (start) begin
						step       <= flash_pkg::step_wren_erase;
						req_r      <= 1'b1;
						busy       <= 1'b1;
						error_flag <= 1'b0;
					end
				end
				flash_pkg::step_finish: begin
					done <= 1'b1;
					busy <= 1'b0;
					step <= flash_pkg::step_idle;
				end
				default: begin
					if (cmd.done) begin
						step  <= step_nxt;
						req_r <= (step_nxt != flash_pkg::step_finish);
					end
				end
			endcase
		end
	end

	// ------------------------------------------------------------------------
	// pattern out under credit, status and read-back in
	// ------------------------------------------------------------------------
	assign wr_send = (step == flash_pkg::step_program) && (wr_idx != IW'(PAGE_BYTES))
	                 && (wr_credit != 2'd0);

	assign wr_bytes.valid  = wr_valid_r;
	assign wr_bytes.data   = wr_data_r;
	assign rd_bytes.credit = rd_cred_r;

	always_ff @(posedge clk_100m or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			wr_idx     <= '0;
			rd_idx     <= '0;
			wr_credit  <= 2'd2;   // engine buffer depth
			wr_valid_r <= 1'b0;
			rd_cred_r  <= 1'b0;
			status_wip <= 1'b0;
		end else begin
			wr_valid_r <= wr_send;
			rd_cred_r  <= rd_bytes.valid;   // consumed at once
			if (cmd.done)
				wr_idx <= '0;
			else if (wr_send)
				wr_idx <= wr_idx + 1'b1;
			if (cmd.done)
				rd_idx <= '0;
			else if (rd_bytes.valid)
				rd_idx <= rd_idx + 1'b1;
			if (is_poll && rd_bytes.valid)
				status_wip <= rd_bytes.data[flash_pkg::wip_bit];
			case ({wr_bytes.credit, wr_send})
				2'b10:   wr_credit <= wr_credit + 2'd1;
				2'b01:   wr_credit <= wr_credit - 2'd1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_100m) begin
		if (wr_send)
			wr_data_r <= 8'(wr_idx) + flash_pkg::pattern_base;
	end

endmodule

/* rtl/flash_test_top.sv */
// flash exerciser top level, sequencer and SPI engine joined by command and byte links
`timescale 1ns/1ps

module flash_test_top #(
	parameter int               PAGE_BYTES     = 16,
	parameter flash_pkg::addr_t TEST_ADDR      = 24'h001000,
	parameter int               CS_HIGH_CYCLES = 4
) (
	input  logic clk_100m,
	input  logic sys_rst_n,
	input  logic start,
	output logic busy,
	output logic done,
	output logic error_flag,

	// flash pins
	output logic spi_cs_n,
	output logic spi_clk,
	output logic spi_mosi,
	input  logic spi_miso
);

	flash_cmd_if  cmd_bus ();
	flash_byte_if wr_bus ();    // sequencer to engine
	flash_byte_if rd_bus ();    // engine to sequencer

	flash_test_seq #(
		.PAGE_BYTES (PAGE_BYTES),
		.TEST_ADDR  (TEST_ADDR)
	) seq_i (
		.clk_100m   (clk_100m),
		.sys_rst_n  (sys_rst_n),
		.start      (start),
		.busy       (busy),
		.done       (done),
		.error_flag (error_flag),
		.cmd        (cmd_bus.seq),
		.wr_bytes   (wr_bus.sender),
		.rd_bytes   (rd_bus.receiver)
	);

	spi_flash_engine #(
		.CS_HIGH_CYCLES (CS_HIGH_CYCLES)
	) engine_i (
		.clk_100m  (clk_100m),
		.sys_rst_n (sys_rst_n),
		.cmd       (cmd_bus.engine),
		.wr_bytes  (wr_bus.receiver),
		.rd_bytes  (rd_bus.sender),
		.spi_cs_n  (spi_cs_n),
		.spi_clk   (spi_clk),
		.spi_mosi  (spi_mosi),
		.spi_miso  (spi_miso)
	);

endmodule

/* test/spi_flash_model.sv */
// behavioral SPI NOR flash with write-enable latch, polled busy time and a read fault switch
`timescale 1ns/1ps

module spi_flash_model #(
	parameter flash_pkg::addr_t TEST_ADDR = 24'h001000
) (
	input  logic spi_cs_n,
	input  logic spi_clk,
	input  logic spi_mosi,
	output logic spi_miso,
	input  logic flip_en     // flips one bit of read byte 5
);

	logic [7:0]       mem [int];   // erased or programmed bytes only
	logic [7:0]       pend [$];    // program data, written when cs rises
	logic [31:0]      rng = 32'd68449;
	logic [7:0]       op = 8'h00;
	logic [7:0]       rx_sh = 8'h00;
	logic [7:0]       tx_sh = 8'h00;
	flash_pkg::addr_t addr = '0;
	logic             wel = 1'b0;
	int               bit_cnt = 0;
	int               byte_cnt = 0;
	int               phase = 0;       // position in the expected opcode order
	int               busy_polls = 0;
	int               proto_errs = 0;

	initial spi_miso = 1'b0;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// untouched bytes hold a pattern of their whole address
	function automatic logic [7:0] peek(input flash_pkg::addr_t a);
		if (mem.exists(int'(a)))
			return mem[int'(a)];
		return a[23:16] ^ a[15:8] ^ a[7:0] ^ 8'h5a;
	endfunction

	function automatic logic [7:0] read_byte(input int k);
		logic [7:0] b;
		b = peek({addr[23:8], addr[7:0] + 8'(k)});   // wraps inside the page
		if (flip_en && k == 5)
			b = b ^ 8'h10;
		return b;
	endfunction

	function automatic logic op_allowed(input logic [7:0] o);
		case (phase)
			0: return o == flash_pkg::op_wren;
			1: return o == flash_pkg::op_sector_erase;
			2: return o == flash_pkg::op_read_status || (o == flash_pkg::op_wren && busy_polls == 0);
			3: return o == flash_pkg::op_page_program;
			default: return o == flash_pkg::op_read_status
			                || (o == flash_pkg::op_read && busy_polls == 0);
		endcase
	endfunction

	// ------------------------------------------------------------------------
	// byte level decode
	// ------------------------------------------------------------------------
	task automatic take_byte(input logic [7:0] b);
		if (byte_cnt == 0) begin
			op    = b;
			tx_sh = 8'h00;
			assert (op_allowed(op)) else begin
				proto_errs++;
				$display("opcode %h arrived out of order", op);
			end
			if (op == flash_pkg::op_sector_erase || op == flash_pkg::op_page_program)
				assert (wel) else begin
					proto_errs++;
					$display("erase or program issued without write enable");
				end
			case (op)
				flash_pkg::op_wren:         phase = (phase == 0) ? 1 : 3;
				flash_pkg::op_sector_erase: phase = 2;
				flash_pkg::op_page_program: phase = 4;
				flash_pkg::op_read:         phase = 0;
				flash_pkg::op_read_status:  tx_sh[flash_pkg::wip_bit] = (busy_polls != 0);
				default: ;
			endcase
		end else if (byte_cnt <= 3) begin
			addr = {addr[15:0], b};
			if (byte_cnt == 3) begin
				assert (addr == TEST_ADDR) else begin
					proto_errs++;
					$display("ERR addr exp %h got %h", TEST_ADDR, addr);
				end
				if (op == flash_pkg::op_read)
					tx_sh = read_byte(0);
			end
		end else if (op == flash_pkg::op_page_program) begin
			pend.push_back(b);
		end else if (op == flash_pkg::op_read) begin
			tx_sh = read_byte(byte_cnt - 3);
		end
	endtask

	always @(negedge spi_cs_n) begin
		bit_cnt  = 0;
		byte_cnt = 0;
		pend.delete();
	end

	always @(posedge spi_clk) begin
		if (!spi_cs_n) begin
			rx_sh = {rx_sh[6:0], spi_mosi};   // mode 0, sample on rise
			bit_cnt++;
			if (bit_cnt == 8) begin
				bit_cnt = 0;
				take_byte(rx_sh);
				byte_cnt++;
			end
		end
	end

	always @(negedge spi_clk) begin
		if (!spi_cs_n) begin
			spi_miso = tx_sh[7];
			tx_sh    = {tx_sh[6:0], 1'b0};
		end
	end

	// command takes effect as chip select rises
	always @(posedge spi_cs_n) begin
		if (byte_cnt > 0) begin
			case (op)
				flash_pkg::op_wren: wel = 1'b1;
				flash_pkg::op_sector_erase: begin
					if (wel)
						for (int i = 0; i < 4096; i++)
							mem[int'({addr[23:12], 12'h000}) + i] = 8'hff;
					wel        = 1'b0;
					rng        = xorshift(rng);
					busy_polls = 3 + int'(rng % 32'd38);
				end
				flash_pkg::op_page_program: begin
					if (wel)
						for (int i = 0; i < pend.size(); i++)
							mem[int'({addr[23:8], addr[7:0] + 8'(i)})] =
								peek({addr[23:8], addr[7:0] + 8'(i)}) & pend[i];
					wel        = 1'b0;
					rng        = xorshift(rng);
					busy_polls = 3 + int'(rng % 32'd38);
				end
				flash_pkg::op_read_status: if (busy_polls > 0) busy_polls--;
				default: ;
			endcase
		end
	end

endmodule

/* test/flash_test_checker.sv */
// protocol assertions on the flash exerciser top-level pins
`timescale 1ns/1ps

module flash_test_checker (
	input logic clk_100m,
	input logic sys_rst_n,
	input logic busy,
	input logic done,
	input logic error_flag,
	input logic spi_cs_n,
	input logic spi_clk,
	input logic spi_mosi
);

	int fail_cnt = 0;   // read by the testbench

	// clock parked low between frames
	clk_idle_a: assert property (@(posedge clk_100m) disable iff (!sys_rst_n)
		spi_cs_n |-> !spi_clk)
	else begin
		fail_cnt++;
		$error("spi_clk went high while chip select was high");
	end

	mosi_stable_a: assert property (@(posedge clk_100m) disable iff (!sys_rst_n)
		spi_clk |-> $stable(spi_mosi))
	else begin
		fail_cnt++;
		$error("mosi changed while spi_clk was high");
	end

	done_pulse_a: assert property (@(posedge clk_100m) disable iff (!sys_rst_n)
		done |=> !done)
	else begin
		fail_cnt++;
		$error("done stayed high for more than one cycle");
	end

	// ------------------------------------------------------------------------
	// outputs right after reset release
	// ------------------------------------------------------------------------
	reset_state_a: assert property (@(posedge clk_100m)
		$rose(sys_rst_n) |-> !busy && !done && !error_flag && spi_cs_n && !spi_clk)
	else begin
		fail_cnt++;
		$error("outputs not in their reset state after reset");
	end

endmodule

bind flash_test_top flash_test_checker chk_i (.*);

/* test/flash_test_tb.sv */
// flash exerciser testbench, clock, reset, three start runs and flash page checks
`timescale 1ns/1ps

module flash_test_tb;

	localparam int               PAGE_BYTES     = 16;
	localparam flash_pkg::addr_t TEST_ADDR      = 24'h001000;
	localparam int               CS_HIGH_CYCLES = 4;
	localparam int               TIMEOUT        = 200000;   // cycles per wait

	logic clk_100m;
	logic sys_rst_n;
	logic start;
	logic flip_en;
	logic busy;
	logic done;
	logic error_flag;
	logic spi_cs_n;
	logic spi_clk;
	logic spi_mosi;
	logic spi_miso;
	int   errs = 0;
	int   total;

	flash_test_top #(
		.PAGE_BYTES     (PAGE_BYTES),
		.TEST_ADDR      (TEST_ADDR),
		.CS_HIGH_CYCLES (CS_HIGH_CYCLES)
	) dut_i (
		.clk_100m   (clk_100m),
		.sys_rst_n  (sys_rst_n),
		.start      (start),
		.busy       (busy),
		.done       (done),
		.error_flag (error_flag),
		.spi_cs_n   (spi_cs_n),
		.spi_clk    (spi_clk),
		.spi_mosi   (spi_mosi),
		.spi_miso   (spi_miso)
	);

	spi_flash_model #(.TEST_ADDR(TEST_ADDR)) flash_i (
		.spi_cs_n (spi_cs_n),
		.spi_clk  (spi_clk),
		.spi_mosi (spi_mosi),
		.spi_miso (spi_miso),
		.flip_en  (flip_en)
	);

	initial begin
		clk_100m = 1'b0;
		forever #5 clk_100m = ~clk_100m;
	end

	task automatic expect_val(input string name, input logic [31:0] exp, input logic [31:0] got);
		assert (got === exp) else begin
			errs++;
			$display("ERR %s exp %h got %h", name, exp, got);
		end
	endtask

	// outputs quiet for n cycles
	task automatic check_idle(input logic exp_err, input int n);
		for (int i = 0; i < n; i++) begin
			@(posedge clk_100m);
			#1;
			expect_val("spi_cs_n", 1, spi_cs_n);
			expect_val("spi_clk", 0, spi_clk);
			expect_val("busy", 0, busy);
			expect_val("done", 0, done);
			expect_val("error_flag", exp_err, error_flag);
		end
	endtask

	// ------------------------------------------------------------------------
	// one start pulse, then wait for done
	// ------------------------------------------------------------------------
	task automatic run_once(input logic flip, input logic exp_err);
		int cycles;
		flip_en = flip;
		@(posedge clk_100m);
		#1 start = 1'b1;
		@(posedge clk_100m);
		#1 start = 1'b0;
		expect_val("busy", 1, busy);   // raised with the start pulse
		cycles = 0;
		while (done !== 1'b1 && cycles < TIMEOUT) begin
			@(posedge clk_100m);
			#1;
			cycles++;
		end
		if (done !== 1'b1) begin
			errs++;
			$display("timeout, no done pulse after start");
		end else begin
			expect_val("error_flag", exp_err, error_flag);
			expect_val("busy", 0, busy);
			expect_val("model_phase", 0, flash_i.phase);   // read frame was seen
			check_idle(exp_err, 8);
		end
	endtask

	task automatic check_page();
		flash_pkg::addr_t a;
		for (int i = 0; i < PAGE_BYTES + 16; i++) begin
			a = TEST_ADDR + 24'(i);
			if (i < PAGE_BYTES)
				expect_val("mem", 8'(i + flash_pkg::pattern_base), flash_i.peek(a));
			else
				expect_val("mem", 8'hff, flash_i.peek(a));   // erased, never programmed
		end
	endtask

	initial begin
		sys_rst_n = 1'b0;
		start     = 1'b0;
		flip_en   = 1'b0;
		repeat (2) @(posedge clk_100m);
		#1 sys_rst_n = 1'b1;
		check_idle(1'b0, 20);
		run_once(1'b0, 1'b0);
		check_page();
		run_once(1'b1, 1'b1);   // faulty read back
		run_once(1'b0, 1'b0);
		check_page();
		total = errs + flash_i.proto_errs + dut_i.chk_i.fail_cnt;
		$display("errors: testbench %0d, flash model %0d, assertions %0d",
		         errs, flash_i.proto_errs, dut_i.chk_i.fail_cnt);
		if (total == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

/* project.f */
rtl/flash_pkg.sv
rtl/flash_ifs.sv
rtl/spi_flash_engine.sv
rtl/flash_test_seq.sv
rtl/flash_test_top.sv
test/spi_flash_model.sv
test/flash_test_checker.sv
test/flash_test_tb.sv
